/* Makefile */
VERILATOR ?= verilator
TOP       ?= sbox_tb
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+100

SOURCES := $(shell cat sources.f)
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): sources.f $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f sources.f

run: $(BIN)
	@out="$$(./$(BIN) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx 'TB PASSED'

clean:
	rm -rf $(OBJ_DIR)

/* bench/sbox_props.sv */
`default_nettype none

module sbox_props import gf64_pkg::*; #(
  parameter int LANES = 4
) (
  input logic                    clk,
  input logic                    rst,
  input logic                    in_valid,
  input logic                    in_ready,
  input logic                    out_valid,
  input logic                    out_ready,
  input logic [LANES*word_w-1:0] out_data
);

  int fails_reset = 0;
  int fails_hold = 0;
  int fails_latency = 0;

  a_reset_clear: assert property (@(posedge clk) rst |=> !out_valid)
    else begin
      fails_reset++;
      $error("out_valid high in the cycle after reset");
    end

  // a stalled output beat must not change
  a_out_hold: assert property (@(posedge clk) disable iff (rst)
      out_valid && !out_ready |=> out_valid && $stable(out_data))
    else begin
      fails_hold++;
      $error("output beat changed or vanished while stalled");
    end

  // accepted at edge n with out_ready high, presented after edge n+2
  a_two_cycle: assert property (@(posedge clk) disable iff (rst)
      $past(in_valid && in_ready, 2) && $past(out_ready, 2) && $past(out_ready)
      |-> out_valid)
    else begin
      fails_latency++;
      $error("accepted beat not presented two cycles later");
    end

endmodule

`default_nettype wire

/* bench/sbox_tb.sv */
`default_nettype none

module sbox_tb import gf64_pkg::*; ();

  localparam int LANES = 4;
  localparam int DW = LANES * word_w;
  localparam int FIX_BEATS = 8;
  localparam int PERM_BEATS = 64 / LANES;
  localparam int RT_BEATS = 32;  // per direction, four passes per round trip test
  localparam int LANE_BEATS = 16;
  localparam int TOTAL_BEATS = FIX_BEATS + PERM_BEATS + 8 * RT_BEATS + 2 * LANE_BEATS;
  localparam int CYCLE_LIMIT = 4 * TOTAL_BEATS + 200;

  localparam int CHK_STORE = 0;
  localparam int CHK_EQUAL = 1;
  localparam int CHK_DISTINCT = 2;

  logic          clk;
  logic          rst;
  logic          in_valid;
  logic          in_ready;
  logic          in_inverse;
  logic [DW-1:0] in_data;
  logic          out_valid;
  logic          out_ready;
  logic [DW-1:0] out_data;

  int seed = 32'had1aeef4;
  bit ready_stall;
  int cycles;
  int check_kind;
  int test_no;
  int exp_base;
  int main_errors;
  int mon_errors = 0;
  int seen_test = -1;
  int in_flight = 0;
  int errs_mark;
  int tests_passed;
  int tests_failed;
  bit [63:0] seen;

  logic [DW-1:0] exp_q[$];
  logic [DW-1:0] got_q[$];
  logic [DW-1:0] send_q[$];
  logic          send_mode[$];
  logic [DW-1:0] orig_q[$];

  tb_clock #(.PERIOD(20)) u_clk (.clk(clk));

  sbox_top #(.LANES(LANES)) uut (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_inverse(in_inverse),
    .in_data   (in_data),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_data  (out_data)
  );

  bind sbox_pipe sbox_props #(.LANES(LANES)) u_props (
    .clk      (clk),
    .rst      (rst),
    .in_valid (in_valid),
    .in_ready (in_ready),
    .out_valid(out_valid),
    .out_ready(out_ready),
    .out_data (out_data)
  );

  // output monitor, every accepted beat is logged and checked
  always @(posedge clk) begin
    int j;
    int k;
    logic [DW-1:0] exp_word;
    logic [word_w-1:0] w;
    logic exp_ready;
    if (!rst) begin
      // no room only with both stages full and the head beat not leaving
      exp_ready = (in_flight < 2) || out_ready;
      assert (in_ready == exp_ready)
        else begin
          $display("FAIL in_ready got %h exp %h", in_ready, exp_ready);
          mon_errors++;
        end
      if (in_valid && in_ready) in_flight++;
      if (out_valid && out_ready) in_flight--;
    end
    if (!rst && out_valid && out_ready) begin
      j = got_q.size() - exp_base;
      if (seen_test != test_no) begin
        seen = '0;
        seen_test = test_no;
      end
      if (check_kind == CHK_EQUAL) begin
        assert (j < exp_q.size())
          else begin
            $display("output beat %0d arrived with no matching input beat", j);
            mon_errors++;
          end
        if (j < exp_q.size()) begin
          exp_word = exp_q[j];
          for (k = 0; k < LANES; k++) begin
            assert (out_data[k*word_w +: word_w] == exp_word[k*word_w +: word_w])
              else begin
                $display("FAIL out_data lane %0d beat %0d got %h exp %h", k, j,
                         out_data[k*word_w +: word_w], exp_word[k*word_w +: word_w]);
                mon_errors++;
              end
          end
        end
      end else if (check_kind == CHK_DISTINCT) begin
        for (k = 0; k < LANES; k++) begin
          w = out_data[k*word_w +: word_w];
          assert (!seen[w])
            else begin
              $display("FAIL out_data lane %0d got %h which repeats an earlier output", k, w);
              mon_errors++;
            end
          seen[w] = 1'b1;
        end
      end
      got_q.push_back(out_data);
    end
  end

  initial begin
    cycles = 0;
    while (cycles < CYCLE_LIMIT) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
    $display("TB FAILED");
    $finish;
  end

  function automatic int total_errors();
    return mon_errors + main_errors + uut.u_pipe.u_props.fails_reset
         + uut.u_pipe.u_props.fails_hold + uut.u_pipe.u_props.fails_latency;
  endfunction

  task automatic next_cycle();
    @(posedge clk);
    if (ready_stall) out_ready <= (($random(seed) & 3) != 0);
    else out_ready <= 1'b1;
  endtask

  // sends send_q in order, in_valid holds until each beat is taken
  task automatic drive_beats(input bit stall_valid);
    int idx;
    int n;
    bit hold;
    n = send_q.size();
    idx = 0;
    while (idx < n) begin
      next_cycle();
      hold = in_valid && !in_ready;
      if (in_valid && in_ready) idx++;
      if (!hold) begin
        if (idx < n && (!stall_valid || (($random(seed) & 3) != 0))) begin
          in_valid   <= 1'b1;
          in_inverse <= send_mode[idx];
          in_data    <= send_q[idx];
        end else begin
          in_valid <= 1'b0;
        end
      end
    end
  endtask

  task automatic run_beats(input int kind, input bit stall);
    int n;
    n = send_q.size();
    test_no++;
    check_kind = kind;
    exp_base = got_q.size();
    ready_stall = stall;
    drive_beats(stall);
    while (got_q.size() - exp_base < n) next_cycle();
    ready_stall = 1'b0;
    repeat (3) next_cycle();  // anything extra would show up by now
    assert (got_q.size() - exp_base == n)
      else begin
        $display("FAIL beat count got %h exp %h", got_q.size() - exp_base, n);
        main_errors++;
      end
    send_q.delete();
    send_mode.delete();
  endtask

  // orig_q goes through in one mode, the results come back in the other
  task automatic round_trip(input bit first_inverse, input bit stall);
    int base;
    int b;
    base = got_q.size();
    foreach (orig_q[i]) begin
      send_q.push_back(orig_q[i]);
      send_mode.push_back(first_inverse);
    end
    exp_q.delete();
    run_beats(CHK_STORE, stall);
    for (b = 0; b < orig_q.size(); b++) begin
      send_q.push_back(got_q[base + b]);
      send_mode.push_back(!first_inverse);
      exp_q.push_back(orig_q[b]);
    end
    run_beats(CHK_EQUAL, stall);
  endtask

  task automatic fill_random(input int n);
    int r;
    logic [DW-1:0] pat;
    orig_q.delete();
    repeat (n) begin
      for (int k = 0; k < LANES; k++) begin
        r = $random(seed);
        pat[k*word_w +: word_w] = r[word_w-1:0];
      end
      orig_q.push_back(pat);
    end
  endtask

  task automatic report_test(input string name);
    int errs;
    errs = total_errors() - errs_mark;
    errs_mark = total_errors();
    if (errs == 0) begin
      tests_passed++;
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: %0d errors", name, errs);
    end
  endtask

  initial begin
    logic [DW-1:0] pat;
    logic one;
    int w;
    int r;
    rst = 1'b1;
    in_valid = 1'b0;
    in_inverse = 1'b0;
    in_data = '0;
    out_ready = 1'b1;
    ready_stall = 1'b0;
    check_kind = CHK_STORE;
    test_no = 0;
    exp_base = 0;
    main_errors = 0;
    errs_mark = 0;
    tests_passed = 0;
    tests_failed = 0;
    repeat (16) next_cycle();
    rst <= 1'b0;
    next_cycle();

    // 0 and 1 stay put under any power
    exp_q.delete();
    for (int m = 0; m < 2; m++) begin
      for (int p = 0; p < 4; p++) begin
        for (int k = 0; k < LANES; k++) begin
          one = (p == 1) || (p == 2 && k % 2 == 0) || (p == 3 && k % 2 == 1);
          pat[k*word_w +: word_w] = {{(word_w-1){1'b0}}, one};
        end
        send_q.push_back(pat);
        send_mode.push_back(m == 1);
        exp_q.push_back(pat);
      end
    end
    run_beats(CHK_EQUAL, 1'b0);
    report_test("fixed_points");

    for (int b = 0; b < PERM_BEATS; b++) begin
      for (int k = 0; k < LANES; k++) begin
        w = b * LANES + k;
        pat[k*word_w +: word_w] = w[word_w-1:0];
      end
      send_q.push_back(pat);
      send_mode.push_back(1'b0);
    end
    run_beats(CHK_DISTINCT, 1'b0);
    report_test("permutation");

    fill_random(RT_BEATS);
    round_trip(1'b0, 1'b0);
    fill_random(RT_BEATS);
    round_trip(1'b1, 1'b0);
    report_test("round_trip");

    fill_random(RT_BEATS);
    round_trip(1'b0, 1'b1);
    fill_random(RT_BEATS);
    round_trip(1'b1, 1'b1);
    report_test("back_pressure");

    // each lane follows its own pattern
    orig_q.delete();
    for (int i = 0; i < LANE_BEATS; i++) begin
      r = $random(seed);
      for (int k = 0; k < LANES; k++) begin
        case (k % 4)
          0: w = i * 5 + 1;
          1: w = r;
          2: w = 63 - i;
          default: w = i % 2;
        endcase
        pat[k*word_w +: word_w] = w[word_w-1:0];
      end
      orig_q.push_back(pat);
    end
    round_trip(1'b0, 1'b0);
    report_test("lane_independence");

    $display("tests passed %0d failed %0d, errors %0d", tests_passed, tests_failed,
             total_errors());
    if (tests_failed == 0 && total_errors() == 0) $display("TB PASSED");
    else $display("TB FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* bench/tb_clock.sv */
`default_nettype none

module tb_clock #(
  parameter int PERIOD = 20
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

endmodule

`default_nettype wire

/* hw/gf64_pkg.sv */
`default_nettype none

package gf64_pkg;

  localparam int word_w = 6;

  // tower word: three GF(4) digits over the normal basis e0, e1, e2
  typedef union packed {
    logic [word_w-1:0] flat;
    struct packed {
      logic [1:0] d2;
      logic [1:0] d1;
      logic [1:0] d0;
    } dig;
  } tower_word_u;

  // GF(4) with w^2 = w + 1, bit 1 is the w coefficient
  function automatic logic [1:0] gf4_sq(input logic [1:0] a);
    return {a[1], a[0] ^ a[1]};
  endfunction

  function automatic logic [1:0] gf4_mul(input logic [1:0] a, input logic [1:0] b);
    logic hi;
    hi = a[1] & b[1];
    return {(a[0] & b[1]) ^ (a[1] & b[0]) ^ hi, (a[0] & b[0]) ^ hi};
  endfunction

  // a^3 * b, where a^3 is 1 for every nonzero digit
  function automatic logic [1:0] gf4_cube_scale(input logic [1:0] a, input logic [1:0] b);
    logic nz;
    nz = a[0] ^ (~a[0] & a[1]);
    return b & {2{nz}};
  endfunction

  function automatic tower_word_u to_tower(input logic [word_w-1:0] p);
    tower_word_u t;
    t.flat[0] = p[0] ^ p[4] ^ p[5];
    t.flat[1] = p[2] ^ p[4];
    t.flat[2] = p[0] ^ p[2] ^ p[3];
    t.flat[3] = p[1] ^ p[2] ^ p[3] ^ p[5];
    t.flat[4] = p[0] ^ p[1] ^ p[2];
    t.flat[5] = p[1] ^ p[4] ^ p[5];
    return t;
  endfunction

  // exact inverse of to_tower, so 1 maps back to 1
  function automatic logic [word_w-1:0] from_tower(input tower_word_u t);
    logic [word_w-1:0] b;
    logic [word_w-1:0] p;
    b = t.flat;
    p[0] = b[0] ^ b[1] ^ b[2] ^ b[3] ^ b[4];
    p[1] = b[1] ^ b[2] ^ b[3] ^ b[4] ^ b[5];
    p[2] = b[0] ^ b[4] ^ b[5];
    p[3] = b[1] ^ b[3] ^ b[5];
    p[4] = b[0] ^ b[1] ^ b[4] ^ b[5];
    p[5] = b[0] ^ b[2] ^ b[3] ^ b[5];
    return p;
  endfunction

endpackage

`default_nettype wire

/* hw/gf64_tower_mul.sv */
`default_nettype none

module gf64_tower_mul import gf64_pkg::*; (
  input  tower_word_u a,
  input  tower_word_u b,
  output tower_word_u c
);

  logic [1:0] m00, m01, m02;
  logic [1:0] m10, m11, m12;
  logic [1:0] m20, m21, m22;
  logic [1:0] x01, x02, x12;

  // schoolbook digit products
  assign m00 = gf4_mul(a.dig.d0, b.dig.d0);
  assign m01 = gf4_mul(a.dig.d0, b.dig.d1);
  assign m02 = gf4_mul(a.dig.d0, b.dig.d2);
  assign m10 = gf4_mul(a.dig.d1, b.dig.d0);
  assign m11 = gf4_mul(a.dig.d1, b.dig.d1);
  assign m12 = gf4_mul(a.dig.d1, b.dig.d2);
  assign m20 = gf4_mul(a.dig.d2, b.dig.d0);
  assign m21 = gf4_mul(a.dig.d2, b.dig.d1);
  assign m22 = gf4_mul(a.dig.d2, b.dig.d2);

  assign x01 = m01 ^ m10;  // weight of e0*e1
  assign x02 = m02 ^ m20;
  assign x12 = m12 ^ m21;

  // reduction: e0^2 = e2, e1^2 = e0, e2^2 = e1,
  // e0*e1 = e1 + e2, e1*e2 = e2 + e0, e2*e0 = e0 + e1
  assign c.dig.d0 = m11 ^ x12 ^ x02;
  assign c.dig.d1 = m22 ^ x01 ^ x02;
  assign c.dig.d2 = m00 ^ x01 ^ x12;

endmodule

`default_nettype wire

/* hw/power20_core.sv */
`default_nettype none

module power20_core import gf64_pkg::*; (
  input  tower_word_u a,
  output tower_word_u b
);

  tower_word_u x2, x4, x5, x10;

  // squaring in the normal basis: square each digit, then rotate
  // since e0^2 = e2, e1^2 = e0, e2^2 = e1
  function automatic tower_word_u tower_sq(input tower_word_u x);
    tower_word_u y;
    y.dig.d0 = gf4_sq(x.dig.d1);
    y.dig.d1 = gf4_sq(x.dig.d2);
    y.dig.d2 = gf4_sq(x.dig.d0);
    return y;
  endfunction

  assign x2 = tower_sq(a);
  assign x4 = tower_sq(x2);

  gf64_tower_mul u_mul (
    .a(x4),
    .b(a),
    .c(x5)  // x^5
  );

  assign x10 = tower_sq(x5);
  assign b   = tower_sq(x10);  // x^20, inverse of x^41 since 820 = 1 mod 63

endmodule

`default_nettype wire

/* hw/power41_core.sv */
`default_nettype none

module power41_core import gf64_pkg::*; (
  input  tower_word_u a,
  output tower_word_u b
);

  logic [1:0] s0, s1, s2;                 // digit squares
  logic [1:0] c10, c20, c01, c21, c02, c12; // cube scaled cross terms
  logic [1:0] p01, p02, p12;
  logic [1:0] q01, q02, q12;
  logic [1:0] t0, t1, t2;

  assign s0 = gf4_sq(a.dig.d0);
  assign s1 = gf4_sq(a.dig.d1);
  assign s2 = gf4_sq(a.dig.d2);

  // cij = di^3 * sj
  assign c10 = gf4_cube_scale(a.dig.d1, s0);
  assign c20 = gf4_cube_scale(a.dig.d2, s0);
  assign c01 = gf4_cube_scale(a.dig.d0, s1);
  assign c21 = gf4_cube_scale(a.dig.d2, s1);
  assign c02 = gf4_cube_scale(a.dig.d0, s2);
  assign c12 = gf4_cube_scale(a.dig.d1, s2);

  assign p01 = gf4_mul(a.dig.d0, a.dig.d1);
  assign p02 = gf4_mul(a.dig.d0, a.dig.d2);
  assign p12 = gf4_mul(a.dig.d1, a.dig.d2);

  // one digit times the product of the other two squares
  assign q12 = gf4_mul(s1, s2);
  assign q02 = gf4_mul(s0, s2);
  assign q01 = gf4_mul(s0, s1);
  assign t0  = gf4_mul(a.dig.d0, q12);
  assign t1  = gf4_mul(a.dig.d1, q02);
  assign t2  = gf4_mul(a.dig.d2, q01);

  // each output digit is a rotation of the same nine term sum
  assign b.dig.d0 = s0 ^ s1
                  ^ c10 ^ c20 ^ c12
                  ^ p01 ^ p02
                  ^ t0 ^ t2;

  assign b.dig.d1 = s1 ^ s2
                  ^ c20 ^ c01 ^ c21
                  ^ p01 ^ p12
                  ^ t0 ^ t1;

  assign b.dig.d2 = s0 ^ s2
                  ^ c01 ^ c02 ^ c12
                  ^ p02 ^ p12
                  ^ t1 ^ t2;

endmodule

`default_nettype wire

/* hw/sbox_lane.sv */
`default_nettype none

module sbox_lane import gf64_pkg::*; (
  input  tower_word_u       tower_in,
  input  logic              inverse,
  output logic [word_w-1:0] word_out
);

  tower_word_u pow41;
  tower_word_u pow20;
  tower_word_u sel;

  // both powers are evaluated every cycle, the mode picks one
  power41_core u_p41 (
    .a(tower_in),
    .b(pow41)
  );

  power20_core u_p20 (
    .a(tower_in),
    .b(pow20)
  );

  assign sel = inverse ? pow20 : pow41;

  assign word_out = from_tower(sel);  // back to polynomial basis

endmodule

`default_nettype wire

/* hw/sbox_pipe.sv */
`default_nettype none

module sbox_pipe import gf64_pkg::*; #(
  parameter int LANES = 4
) (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    in_valid,
  output logic                    in_ready,
  input  logic                    in_inverse,
  input  logic [LANES*word_w-1:0] in_data,
  output logic                    out_valid,
  input  logic                    out_ready,
  output logic [LANES*word_w-1:0] out_data
);

  logic                    s1_valid;
  logic                    s1_inverse;
  logic                    s1_en;
  logic                    s1_load;
  logic                    s2_valid;
  logic                    s2_en;
  logic                    s2_load;
  logic [LANES*word_w-1:0] lane_out;
  logic [LANES*word_w-1:0] s2_data;

  // a stage moves when it is empty or the next one takes its beat
  assign s2_en = !s2_valid || out_ready;
  assign s1_en = !s1_valid || s2_en;

  assign in_ready = s1_en;
  assign s1_load  = in_valid && s1_en;
  assign s2_load  = s1_valid && s2_en;

  always_ff @(posedge clk) begin
    if (rst) begin
      s1_valid <= 1'b0;
      s2_valid <= 1'b0;
    end else begin
      if (s1_en) s1_valid <= in_valid;
      if (s2_en) s2_valid <= s1_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (s1_load) s1_inverse <= in_inverse;
    if (s2_load) s2_data <= lane_out;  // held while out_ready is low
  end

  for (genvar k = 0; k < LANES; k++) begin : g_lane
    tower_word_u s1_word;  // stage 1 keeps the tower form

    always_ff @(posedge clk) begin
      if (s1_load) begin
        s1_word <= to_tower(in_data[k*word_w +: word_w]);
      end
    end

    sbox_lane u_lane (
      .tower_in(s1_word),
      .inverse (s1_inverse),
      .word_out(lane_out[k*word_w +: word_w])
    );
  end

  assign out_valid = s2_valid;
  assign out_data  = s2_data;

endmodule

`default_nettype wire

/* hw/sbox_top.sv */
`default_nettype none

module sbox_top import gf64_pkg::*; #(
  parameter int LANES = 4
) (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    in_valid,
  output logic                    in_ready,
  input  logic                    in_inverse,
  input  logic [LANES*word_w-1:0] in_data,  // lane k at bits 6k upward
  output logic                    out_valid,
  input  logic                    out_ready,
  output logic [LANES*word_w-1:0] out_data
);

  sbox_pipe #(
    .LANES(LANES)
  ) u_pipe (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_inverse(in_inverse),
    .in_data   (in_data),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_data  (out_data)
  );

endmodule

`default_nettype wire

/* sources.f */
hw/gf64_pkg.sv
hw/gf64_tower_mul.sv
hw/power41_core.sv
hw/power20_core.sv
hw/sbox_lane.sv
hw/sbox_pipe.sv
hw/sbox_top.sv
bench/tb_clock.sv
bench/sbox_props.sv
bench/sbox_tb.sv
